// File: wb_pkg.sv
package wb_pkg;

	localparam int WB_AW = 32;
	localparam int WB_DW = 32;

	// cycle type identifiers
	localparam logic [2:0] CTI_CLASSIC = 3'b000;
	localparam logic [2:0] CTI_INC     = 3'b010;
	localparam logic [2:0] CTI_EOB     = 3'b111;

	// burst type extension, 8 and 16 beat wraps run linear
	localparam logic [1:0] BTE_LINEAR = 2'b00;
	localparam logic [1:0] BTE_BEAT4  = 2'b01;

	typedef struct packed {
		logic [WB_AW-1:0]   adr;
		logic [1:0]         bte;
		logic [2:0]         cti;
		logic [WB_DW-1:0]   dat;
		logic [WB_DW/8-1:0] sel;
		logic               we;
		logic               stb; // low marks an idle slot
	} wb_entry_t;

	localparam int CYC_COUNT = 32;
	localparam int RUN_IDX_W = 5;

	localparam wb_entry_t CYC_TABLE [CYC_COUNT] = '{
		1:  '{32'h0000_0100, BTE_LINEAR, CTI_CLASSIC, 32'h1234_5678, 4'b1111, 1'b1, 1'b1},
		2:  '{32'h0000_0100, BTE_LINEAR, CTI_CLASSIC, 32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		4:  '{32'h0000_A000, BTE_BEAT4,  CTI_INC,     32'h0001_0002, 4'b1111, 1'b1, 1'b1},
		5:  '{32'h0000_A004, BTE_BEAT4,  CTI_INC,     32'h0003_0004, 4'b1111, 1'b1, 1'b1},
		6:  '{32'h0000_A008, BTE_BEAT4,  CTI_INC,     32'h0005_0006, 4'b1111, 1'b1, 1'b1},
		7:  '{32'h0000_A00C, BTE_BEAT4,  CTI_EOB,     32'h0007_0008, 4'b1111, 1'b1, 1'b1},
		8:  '{32'h0000_A008, BTE_LINEAR, CTI_CLASSIC, 32'hA1FF_FFFF, 4'b1000, 1'b1, 1'b1},
		9:  '{32'h0000_A000, BTE_BEAT4,  CTI_INC,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		10: '{32'h0000_A004, BTE_BEAT4,  CTI_INC,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		11: '{32'h0000_A008, BTE_BEAT4,  CTI_INC,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		12: '{32'h0000_A00C, BTE_BEAT4,  CTI_EOB,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		13: '{32'h0000_1000, BTE_LINEAR, CTI_INC,     32'hDEAD_DEAD, 4'b1111, 1'b1, 1'b1},
		14: '{32'h0000_1004, BTE_LINEAR, CTI_EOB,     32'h5555_5555, 4'b1111, 1'b1, 1'b1},
		15: '{32'h0000_1000, BTE_LINEAR, CTI_INC,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		16: '{32'h0000_1004, BTE_LINEAR, CTI_EOB,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		17: '{32'h0000_A008, BTE_BEAT4,  CTI_INC,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		18: '{32'h0000_A00C, BTE_BEAT4,  CTI_INC,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		19: '{32'h0000_A000, BTE_BEAT4,  CTI_INC,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		20: '{32'h0000_A004, BTE_BEAT4,  CTI_EOB,     32'h0000_0000, 4'b1111, 1'b0, 1'b1},
		default: '0
	};

	// read data before the run pattern is applied
	localparam logic [WB_DW-1:0] CYC_EXPECT [CYC_COUNT] = '{
		2:  32'h1234_5678,
		9:  32'h0001_0002,
		10: 32'h0003_0004,
		11: 32'hA105_0006, // byte lane 3 from entry 8
		12: 32'h0007_0008,
		15: 32'hDEAD_DEAD,
		16: 32'h5555_5555,
		17: 32'hA105_0006,
		18: 32'h0007_0008,
		19: 32'h0001_0002,
		20: 32'h0003_0004,
		default: '0
	};

endpackage

// File: wb_cycle_rom.sv
`timescale 1ns/10ps

module wb_cycle_rom #(
	parameter int ROM_DEPTH = wb_pkg::CYC_COUNT
) (
	input  logic                         clk,
	input  logic [wb_pkg::RUN_IDX_W-1:0] idx_i,
	output wb_pkg::wb_entry_t            entry_o
);

	wb_pkg::wb_entry_t rom [ROM_DEPTH];

	// slots past the package table read as idle
	genvar g;
	generate
		for (g = 0; g < ROM_DEPTH; g++) begin : g_rom
			if (g < wb_pkg::CYC_COUNT) begin : g_used
				assign rom[g] = wb_pkg::CYC_TABLE[g];
			end else begin : g_pad
				assign rom[g] = '0;
			end
		end
	endgenerate

	// one cycle latency
	always_ff @(posedge clk) begin
		if (32'(idx_i) < ROM_DEPTH) begin
			entry_o <= rom[idx_i];
		end else begin
			entry_o <= '0; // stb low, idle slot
		end
	end

endmodule

// File: wb_seq_master.sv
`timescale 1ns/10ps

module wb_seq_master (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           go_i,
	input  logic [wb_pkg::RUN_IDX_W-1:0]   first_i,
	input  logic [wb_pkg::RUN_IDX_W-1:0]   last_i,
	input  logic [wb_pkg::WB_DW-1:0]       pattern_i,
	output logic                           done_o,
	output logic [wb_pkg::RUN_IDX_W-1:0]   idx_o,
	input  wb_pkg::wb_entry_t              entry_i,
	output logic [wb_pkg::WB_AW-1:0]       adr_o,
	output logic [wb_pkg::WB_DW-1:0]       dat_o,
	output logic [wb_pkg::WB_DW/8-1:0]     sel_o,
	output logic                           we_o,
	output logic                           cyc_o,
	output logic                           stb_o,
	output logic [2:0]                     cti_o,
	output logic [1:0]                     bte_o,
	input  logic [wb_pkg::WB_DW-1:0]       dat_i,
	input  logic                           ack_i,
	output logic [7:0]                     err_count_o,
	output logic [15:0]                    beats_o,
	output logic [wb_pkg::WB_DW-1:0]       rd_sum_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_BUS,
		S_FINISH
	} state_t;

	state_t state;
	logic [wb_pkg::RUN_IDX_W-1:0] cur;
	logic burst_open;
	logic in_bus;
	logic advance;
	logic last_hit;
	logic beat_ack;
	logic clear;
	logic [wb_pkg::WB_DW-1:0] expect_dat;

	assign in_bus   = (state == S_BUS);
	assign last_hit = (cur == last_i);
	assign beat_ack = stb_o & ack_i;
	// idle slots step on their own, bus slots wait for ack
	assign advance  = in_bus & (entry_i.stb ? ack_i : 1'b1);

	// table index runs one ahead so burst beats come back to back
	assign idx_o = (advance && !last_hit) ? cur + 1'b1 : cur;

	assign stb_o = in_bus & entry_i.stb;
	assign cyc_o = in_bus & (entry_i.stb | burst_open); // held over burst beats
	assign adr_o = entry_i.adr;
	assign sel_o = entry_i.sel;
	assign we_o  = in_bus & entry_i.we;
	assign cti_o = entry_i.cti;
	assign bte_o = entry_i.bte;
	assign dat_o = entry_i.we ? (entry_i.dat ^ pattern_i) : '0;

	assign expect_dat = wb_pkg::CYC_EXPECT[cur] ^ pattern_i;

	// an empty range latched while idle also wipes the status
	assign clear = go_i | ((state == S_IDLE) && (last_i < first_i));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state      <= S_IDLE;
			cur        <= '0;
			done_o     <= 1'b0;
			burst_open <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				S_IDLE: begin
					if (go_i) begin
						cur   <= first_i;
						state <= S_FETCH;
					end
				end
				S_FETCH: state <= S_BUS; // table output lands next cycle
				S_BUS: begin
					if (advance) begin
						if (last_hit) begin
							state  <= S_FINISH;
							done_o <= 1'b1;
						end else begin
							cur <= cur + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase

			if (!in_bus)
				burst_open <= 1'b0;
			else if (beat_ack)
				burst_open <= (entry_i.cti == wb_pkg::CTI_INC);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			err_count_o <= '0;
			beats_o     <= '0;
			rd_sum_o    <= '0;
		end else if (clear) begin
			err_count_o <= '0;
			beats_o     <= '0;
			rd_sum_o    <= '0;
		end else if (beat_ack) begin
			beats_o <= beats_o + 1'b1;
			if (!entry_i.we) begin
				rd_sum_o <= rd_sum_o ^ dat_i;
				if (dat_i != expect_dat)
					err_count_o <= err_count_o + 1'b1; // mismatch on this read
			end
		end
	end

endmodule

// File: wb_run_ctrl.sv
`timescale 1ns/10ps

module wb_run_ctrl (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         run_req_i,
	input  logic [wb_pkg::RUN_IDX_W-1:0] run_first_i,
	input  logic [wb_pkg::RUN_IDX_W-1:0] run_last_i,
	input  logic [wb_pkg::WB_DW-1:0]     pattern_i,
	output logic                         run_ack_o,
	output logic                         go_o,
	output logic [wb_pkg::RUN_IDX_W-1:0] first_o,
	output logic [wb_pkg::RUN_IDX_W-1:0] last_o,
	output logic [wb_pkg::WB_DW-1:0]     pattern_o,
	input  logic                         done_i
);

	typedef enum logic [1:0] {
		C_IDLE,
		C_BUSY,
		C_SKIP,
		C_ACK
	} state_t;

	state_t state;
	logic req_q;
	logic req_rise;

	assign req_rise = run_req_i & ~req_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= C_IDLE;
			req_q     <= 1'b0;
			go_o      <= 1'b0;
			run_ack_o <= 1'b0;
		end else begin
			req_q <= run_req_i;
			go_o  <= 1'b0;
			case (state)
				C_IDLE: begin
					if (req_rise) begin
						if (run_last_i < run_first_i) begin
							state <= C_SKIP; // nothing to play
						end else begin
							go_o  <= 1'b1;
							state <= C_BUSY;
						end
					end
				end
				C_BUSY: begin
					if (done_i) begin
						run_ack_o <= 1'b1;
						state     <= C_ACK;
					end
				end
				// gives the sequencer a cycle to clear its status
				C_SKIP: begin
					run_ack_o <= 1'b1;
					state     <= C_ACK;
				end
				default: begin
					if (!run_req_i) begin
						run_ack_o <= 1'b0; // four-phase return to zero
						state     <= C_IDLE;
					end
				end
			endcase
		end
	end

	// run settings, held for the whole run
	always_ff @(posedge clk) begin
		if (state == C_IDLE && req_rise) begin
			first_o   <= run_first_i;
			last_o    <= run_last_i;
			pattern_o <= pattern_i;
		end
	end

endmodule

// File: wb_burst_ram.sv
`timescale 1ns/10ps

module wb_burst_ram #(
	parameter int RAM_AW = 14
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [wb_pkg::WB_AW-1:0]   adr_i,
	input  logic [wb_pkg::WB_DW-1:0]   dat_i,
	input  logic [wb_pkg::WB_DW/8-1:0] sel_i,
	input  logic                       we_i,
	input  logic                       cyc_i,
	input  logic                       stb_i,
	input  logic [2:0]                 cti_i,
	input  logic [1:0]                 bte_i,
	output logic [wb_pkg::WB_DW-1:0]   dat_o,
	output logic                       ack_o
);

	logic [wb_pkg::WB_DW-1:0] mem [2**RAM_AW];

	logic [RAM_AW-1:0] word_adr;
	logic [RAM_AW-1:0] next_adr;
	logic [RAM_AW-1:0] rd_adr;
	logic beat_done;
	logic burst_cont;

	assign word_adr = adr_i[RAM_AW+1:2];

	// predicted address of the following beat
	always_comb begin
		if (bte_i == wb_pkg::BTE_BEAT4)
			next_adr = {word_adr[RAM_AW-1:2], word_adr[1:0] + 2'd1}; // wrap in 4 words
		else
			next_adr = word_adr + 1'b1;
	end

	assign beat_done  = cyc_i & stb_i & ack_o;
	assign burst_cont = beat_done & (cti_i == wb_pkg::CTI_INC); // burst still open

	// while a burst is open, fetch ahead so the next beat is ready
	assign rd_adr = burst_cont ? next_adr : word_adr;

	// first beat waits a cycle, then acks run until classic or eob
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			ack_o <= 1'b0;
		else
			ack_o <= cyc_i & stb_i & (~ack_o | (cti_i == wb_pkg::CTI_INC));
	end

	always_ff @(posedge clk) begin
		if (beat_done && we_i) begin
			for (int b = 0; b < wb_pkg::WB_DW/8; b++) begin
				if (sel_i[b])
					mem[word_adr][8*b +: 8] <= dat_i[8*b +: 8];
			end
		end
		if (cyc_i && stb_i)
			dat_o <= mem[rd_adr];
	end

endmodule

// File: wb_sys_top.sv
`timescale 1ns/10ps

module wb_sys_top #(
	parameter int RAM_AW = 14
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         run_req_i,
	input  logic [wb_pkg::RUN_IDX_W-1:0] run_first_i,
	input  logic [wb_pkg::RUN_IDX_W-1:0] run_last_i,
	input  logic [wb_pkg::WB_DW-1:0]     pattern_i,
	output logic                         run_ack_o,
	output logic [7:0]                   err_count_o,
	output logic [15:0]                  beats_o,
	output logic [wb_pkg::WB_DW-1:0]     rd_sum_o
);

	localparam int ROM_DEPTH = wb_pkg::CYC_COUNT;

	// control to sequencer
	logic                         go;
	logic                         done;
	logic [wb_pkg::RUN_IDX_W-1:0] first;
	logic [wb_pkg::RUN_IDX_W-1:0] last;
	logic [wb_pkg::WB_DW-1:0]     pattern;

	// table lookup
	logic [wb_pkg::RUN_IDX_W-1:0] idx;
	wb_pkg::wb_entry_t            entry;

	// wishbone
	logic [wb_pkg::WB_AW-1:0]   wb_adr;
	logic [wb_pkg::WB_DW-1:0]   wb_dat_m2s;
	logic [wb_pkg::WB_DW-1:0]   wb_dat_s2m;
	logic [wb_pkg::WB_DW/8-1:0] wb_sel;
	logic                       wb_we;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic [2:0]                 wb_cti;
	logic [1:0]                 wb_bte;
	logic                       wb_ack;

	wb_run_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.run_req_i   (run_req_i),
		.run_first_i (run_first_i),
		.run_last_i  (run_last_i),
		.pattern_i   (pattern_i),
		.run_ack_o   (run_ack_o),
		.go_o        (go),
		.first_o     (first),
		.last_o      (last),
		.pattern_o   (pattern),
		.done_i      (done)
	);

	wb_seq_master u_seq (
		.clk         (clk),
		.reset       (reset),
		.go_i        (go),
		.first_i     (first),
		.last_i      (last),
		.pattern_i   (pattern),
		.done_o      (done),
		.idx_o       (idx),
		.entry_i     (entry),
		.adr_o       (wb_adr),
		.dat_o       (wb_dat_m2s),
		.sel_o       (wb_sel),
		.we_o        (wb_we),
		.cyc_o       (wb_cyc),
		.stb_o       (wb_stb),
		.cti_o       (wb_cti),
		.bte_o       (wb_bte),
		.dat_i       (wb_dat_s2m),
		.ack_i       (wb_ack),
		.err_count_o (err_count_o),
		.beats_o     (beats_o),
		.rd_sum_o    (rd_sum_o)
	);

	wb_cycle_rom #(
		.ROM_DEPTH (ROM_DEPTH)
	) u_rom (
		.clk     (clk),
		.idx_i   (idx),
		.entry_o (entry)
	);

	wb_burst_ram #(
		.RAM_AW (RAM_AW)
	) u_ram (
		.clk   (clk),
		.reset (reset),
		.adr_i (wb_adr),
		.dat_i (wb_dat_m2s),
		.sel_i (wb_sel),
		.we_i  (wb_we),
		.cyc_i (wb_cyc),
		.stb_i (wb_stb),
		.cti_i (wb_cti),
		.bte_i (wb_bte),
		.dat_o (wb_dat_s2m),
		.ack_o (wb_ack)
	);

endmodule

// File: tb_wb_ref.svh
`ifndef TB_WB_REF_SVH
`define TB_WB_REF_SVH

// word model of the slave memory, unwritten words read as zero
logic [31:0] model_mem [logic [29:0]];

function automatic logic [31:0] model_read(input logic [31:0] adr);
	if (model_mem.exists(adr[31:2]))
		return model_mem[adr[31:2]];
	return 32'h0;
endfunction

// byte lanes merged like the slave's write enables
function automatic void model_write(input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
	logic [31:0] word;
	int b;
	word = model_read(adr);
	for (b = 0; b < 4; b++) begin
		if (sel[b])
			word[8*b +: 8] = dat[8*b +: 8];
	end
	model_mem[adr[31:2]] = word;
endfunction

// expected status of one run over the table, memory follows the writes
function automatic void replay_table(input int first, input int last,
		input logic [31:0] pat, output logic [7:0] err, output logic [15:0] beats,
		output logic [31:0] sum);
	wb_pkg::wb_entry_t e;
	logic [31:0] rd;
	int i;
	err   = 8'd0;
	beats = 16'd0;
	sum   = 32'h0;
	for (i = first; i <= last; i++) begin
		e = wb_pkg::CYC_TABLE[i];
		if (e.stb) begin // idle slots give no beat
			beats = beats + 16'd1;
			if (e.we) begin
				model_write(e.adr, e.dat ^ pat, e.sel);
			end else begin
				rd  = model_read(e.adr);
				sum = sum ^ rd;
				if (rd != (wb_pkg::CYC_EXPECT[i] ^ pat))
					err = err + 8'd1;
			end
		end
	end
endfunction

`endif

// File: tb_wb_sys.sv
`timescale 1ns/10ps

module tb_wb_sys;

	localparam int TIMEOUT = 200; // cycles allowed per wait

	logic        clk;
	logic        reset;
	logic        run_req;
	logic [4:0]  run_first;
	logic [4:0]  run_last;
	logic [31:0] pattern;
	logic        run_ack;
	logic [7:0]  err_count;
	logic [15:0] beats;
	logic [31:0] rd_sum;

	logic [31:0] lfsr;
	logic [31:0] pat;
	logic [7:0]  exp_err;
	logic [15:0] exp_beats;
	logic [31:0] exp_sum;

	`include "tb_wb_ref.svh"

	wb_sys_top #(
		.RAM_AW (14)
	) dut_i (
		.clk         (clk),
		.reset       (reset),
		.run_req_i   (run_req),
		.run_first_i (run_first),
		.run_last_i  (run_last),
		.pattern_i   (pattern),
		.run_ack_o   (run_ack),
		.err_count_o (err_count),
		.beats_o     (beats),
		.rd_sum_o    (rd_sum)
	);

	always #2 clk = ~clk;

	// right shift galois form, taps 32 30 26 25
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'hA300_0000;
		return s >> 1;
	endfunction

	function automatic logic [31:0] random_word();
		logic [31:0] w;
		int n;
		w = 32'h0;
		for (n = 0; n < 32; n++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			w    = {w[30:0], lfsr[0]};
		end
		return w;
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual)
			stop_on_error($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
	endtask

	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (run_ack !== level) begin
			if (cycles == TIMEOUT)
				stop_on_error($sformatf("run_ack_o did not go to %0d in time", level));
			@(negedge clk);
			cycles++;
		end
	endtask

	// raise the request and wait for the ack, expected status comes from the model
	task automatic request_run(input int first, input int last, input logic [31:0] p);
		replay_table(first, last, p, exp_err, exp_beats, exp_sum);
		@(negedge clk);
		run_first = 5'(first);
		run_last  = 5'(last);
		pattern   = p;
		run_req   = 1'b1;
		wait_ack(1'b1);
	endtask

	task automatic check_status(input string name);
		check_value({name, " err_count"}, 32'(exp_err), 32'(err_count));
		check_value({name, " beats"}, 32'(exp_beats), 32'(beats));
		check_value({name, " rd_sum"}, exp_sum, rd_sum);
	endtask

	task automatic release_run();
		@(negedge clk);
		run_req = 1'b0;
		wait_ack(1'b0);
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		run_req   = 1'b0;
		run_first = 5'd0;
		run_last  = 5'd0;
		pattern   = 32'h0;
		lfsr      = 32'h20e4;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_value("reset ack", 32'd0, 32'(run_ack));
		check_value("reset err_count", 32'd0, 32'(err_count));
		check_value("reset beats", 32'd0, 32'(beats));
		check_value("reset rd_sum", 32'd0, rd_sum);

		request_run(0, wb_pkg::CYC_COUNT - 1, 32'h0); // whole table, no pattern
		check_status("full range");
		release_run();

		pat = random_word();
		request_run(1, 2, pat);
		check_status("classic pair");
		check_value("classic read data", wb_pkg::CYC_TABLE[1].dat ^ pat, rd_sum);
		release_run();

		// byte lane write lands inside the wrap burst data
		pat = random_word();
		request_run(4, 12, pat);
		check_status("byte merge");
		release_run();

		// data still holds the previous pattern
		pat = random_word();
		request_run(9, 12, pat);
		check_status("reread");
		release_run();

		pat = random_word();
		request_run(13, 16, pat);
		check_status("linear pair");
		repeat (6) begin
			@(negedge clk);
			check_value("ack held", 32'd1, 32'(run_ack));
		end
		release_run();

		// counters of the previous run must not carry over
		pat = random_word();
		request_run(13, 16, pat);
		check_status("back to back");
		release_run();

		request_run(10, 3, random_word()); // empty range
		check_status("empty range");
		release_run();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+.
wb_pkg.sv
wb_cycle_rom.sv
wb_seq_master.sv
wb_run_ctrl.sv
wb_burst_ram.sv
wb_sys_top.sv
tb_wb_sys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the Wishbone exerciser testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f sim.f --top-module tb_wb_sys -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
